/* verilog/memsys_pkg.sv */
package memsys_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////////////////////////

	// SRAM address and word
	localparam int addr_w = 16;
	localparam int data_w = 16;

	// Processor action token for the data port
	localparam int act_w = 32;

	//////////////////////////////////////////////////////////////////////
	// Sequencer states
	//////////////////////////////////////////////////////////////////////

	// rd1 and rd2 hold oe low, fill writes the cache, wb writes the victim
	typedef enum logic [2:0] {
		st_idle = 3'd0,
		st_rd1 = 3'd1,
		st_rd2 = 3'd2,
		st_fill = 3'd3,
		st_wb = 3'd4
	} seq_state_t;

endpackage

/* verilog/fetch_port.sv */
`timescale 1ns/1ps

module fetch_port (
	input logic clk,
	input logic rst,
	input logic if_req,
	input logic [memsys_pkg::addr_w-1:0] if_addr,
	input logic if_serve,
	input logic [memsys_pkg::data_w-1:0] serve_data,
	output logic if_pending,
	output logic if_done,
	output logic [memsys_pkg::data_w-1:0] if_data
);

	logic [memsys_pkg::addr_w-1:0] done_addr;
	logic done_flag;

	// A new fetch is any address other than the last one completed
	assign if_pending = if_req && (if_addr != done_addr);
	assign if_done = done_flag && !if_pending;

	always_ff @(posedge clk) begin
		if (!rst) begin
			done_addr <= '1;
			done_flag <= 1'b0;
		end else if (if_serve) begin
			done_addr <= if_addr;
			done_flag <= 1'b1;
		end
	end

	// Result word
	always_ff @(posedge clk) begin
		if (if_serve)
			if_data <= serve_data;
	end

	a_serve_pending: assert property (@(posedge clk) disable iff (!rst)
		if_serve |-> if_pending);

endmodule

/* verilog/data_port.sv */
`timescale 1ns/1ps

module data_port (
	input logic clk,
	input logic rst,
	input logic ex_req,
	input logic ex_rd,
	input logic [memsys_pkg::act_w-1:0] ex_act,
	input logic ex_serve,
	input logic [memsys_pkg::data_w-1:0] serve_data,
	output logic ex_pending,
	output logic ex_done,
	output logic [memsys_pkg::data_w-1:0] ex_data,
	output logic [memsys_pkg::act_w-1:0] ex_act_done
);

	logic [memsys_pkg::act_w-1:0] act_done;
	logic done_flag;

	// Token mismatch marks a fresh load or store
	assign ex_pending = ex_req && (ex_act != act_done);
	assign ex_done = done_flag && !ex_pending;
	assign ex_act_done = act_done;

	always_ff @(posedge clk) begin
		if (!rst) begin
			act_done <= '1;
			done_flag <= 1'b0;
		end else if (ex_serve) begin
			act_done <= ex_act;
			done_flag <= 1'b1;
		end
	end

	// Only loads return a word, a store keeps the old one
	always_ff @(posedge clk) begin
		if (ex_serve && ex_rd)
			ex_data <= serve_data;
	end

	a_serve_pending: assert property (@(posedge clk) disable iff (!rst)
		ex_serve |-> ex_pending);

endmodule

/* verilog/line_cache.sv */
`timescale 1ns/1ps

module line_cache #(
	parameter int lines = 64
) (
	input logic clk,
	input logic rst,
	input logic [memsys_pkg::addr_w-1:0] cache_addr,
	input logic cache_wr,
	input logic [memsys_pkg::data_w-1:0] cache_wdata,
	input logic cache_dirty_set,
	output logic hit,
	output logic [memsys_pkg::data_w-1:0] hit_data,
	output logic victim_need,
	output logic [memsys_pkg::addr_w-1:0] victim_addr,
	output logic [memsys_pkg::data_w-1:0] victim_data
);

	localparam int idx_w = $clog2(lines);
	localparam int tag_w = memsys_pkg::addr_w - idx_w;

	//////////////////////////////////////////////////////////////////////
	// Line storage
	//////////////////////////////////////////////////////////////////////

	logic [tag_w-1:0] tag_mem [lines];
	logic [memsys_pkg::data_w-1:0] data_mem [lines];
	logic [lines-1:0] valid;
	logic [lines-1:0] dirty;

	logic [idx_w-1:0] idx;
	logic [tag_w-1:0] tag;
	logic tag_match;

	// Index from the low bits, tag from the rest
	assign idx = cache_addr[idx_w-1:0];
	assign tag = cache_addr[memsys_pkg::addr_w-1:idx_w];
	assign tag_match = tag_mem[idx] == tag;

	//////////////////////////////////////////////////////////////////////
	// Lookup
	//////////////////////////////////////////////////////////////////////

	assign hit = valid[idx] && tag_match;
	assign hit_data = data_mem[idx];

	// Resident line is dirty and about to be replaced
	assign victim_need = valid[idx] && dirty[idx] && !tag_match;
	assign victim_addr = {tag_mem[idx], idx};
	assign victim_data = data_mem[idx];

	//////////////////////////////////////////////////////////////////////
	// Update
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst) begin
			valid <= '0;
			dirty <= '0;
		end else if (cache_wr) begin
			valid[idx] <= 1'b1;
			// Stores mark the line, fills leave it clean
			dirty[idx] <= cache_dirty_set;
		end
	end

	always_ff @(posedge clk) begin
		if (cache_wr) begin
			tag_mem[idx] <= tag;
			data_mem[idx] <= cache_wdata;
		end
	end

endmodule

/* verilog/sram_sequencer.sv */
`timescale 1ns/1ps

module sram_sequencer #(
	parameter int lines = 64
) (
	input logic clk,
	input logic rst,
	input logic if_pending,
	input logic [memsys_pkg::addr_w-1:0] if_addr,
	input logic ex_pending,
	input logic ex_rd,
	input logic [memsys_pkg::addr_w-1:0] ex_addr,
	input logic [memsys_pkg::data_w-1:0] ex_wdata,
	input logic hit,
	input logic [memsys_pkg::data_w-1:0] hit_data,
	input logic victim_need,
	input logic [memsys_pkg::addr_w-1:0] victim_addr,
	input logic [memsys_pkg::data_w-1:0] victim_data,
	input logic [memsys_pkg::data_w-1:0] ram_din,
	output logic [memsys_pkg::addr_w-1:0] cache_addr,
	output logic cache_wr,
	output logic [memsys_pkg::data_w-1:0] cache_wdata,
	output logic cache_dirty_set,
	output logic if_serve,
	output logic ex_serve,
	output logic [memsys_pkg::data_w-1:0] serve_data,
	output logic [memsys_pkg::addr_w-1:0] ram_addr,
	output logic ram_en,
	output logic ram_oe,
	output logic ram_we,
	output logic [memsys_pkg::data_w-1:0] ram_dout,
	output logic ram_doe,
	output memsys_pkg::seq_state_t state
);

	logic sel_ex;
	logic store_q;
	logic [memsys_pkg::addr_w-1:0] addr_q;
	logic [memsys_pkg::data_w-1:0] wdata_q;
	logic serve_busy;
	logic take_ex;
	logic take_if;

	// Ports still show pending during their serve pulse
	assign serve_busy = if_serve || ex_serve;
	assign take_ex = (state == memsys_pkg::st_idle) && !serve_busy && ex_pending;
	assign take_if = (state == memsys_pkg::st_idle) && !serve_busy && !ex_pending && if_pending;

	//////////////////////////////////////////////////////////////////////
	// Cache side
	//////////////////////////////////////////////////////////////////////

	// Look up the incoming request while idle, data port first
	always_comb begin
		if (state == memsys_pkg::st_idle)
			cache_addr = ex_pending ? ex_addr : if_addr;
		else
			cache_addr = addr_q;
	end

	assign cache_wr = state == memsys_pkg::st_fill;
	assign cache_dirty_set = store_q;
	assign cache_wdata = store_q ? wdata_q : serve_data;

	//////////////////////////////////////////////////////////////////////
	// State and strobes
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= memsys_pkg::st_idle;
			sel_ex <= 1'b0;
			store_q <= 1'b0;
			if_serve <= 1'b0;
			ex_serve <= 1'b0;
			ram_en <= 1'b1;
			ram_oe <= 1'b1;
			ram_we <= 1'b1;
			ram_doe <= 1'b0;
		end else begin
			if_serve <= 1'b0;
			ex_serve <= 1'b0;
			case (state)
				memsys_pkg::st_idle: begin
					if (take_ex || take_if) begin
						sel_ex <= take_ex;
						store_q <= take_ex && !ex_rd;
						if (take_ex && !ex_rd) begin
							state <= memsys_pkg::st_fill;
						end else if (hit) begin
							if_serve <= take_if;
							ex_serve <= take_ex;
						end else begin
							// Miss, open the read
							ram_en <= 1'b0;
							ram_oe <= 1'b0;
							state <= memsys_pkg::st_rd1;
						end
					end
				end
				memsys_pkg::st_rd1: begin
					state <= memsys_pkg::st_rd2;
				end
				memsys_pkg::st_rd2: begin
					ram_en <= 1'b1;
					ram_oe <= 1'b1;
					state <= memsys_pkg::st_fill;
				end
				memsys_pkg::st_fill: begin
					if (victim_need) begin
						ram_en <= 1'b0;
						ram_we <= 1'b0;
						ram_doe <= 1'b1;
						state <= memsys_pkg::st_wb;
					end else begin
						if_serve <= !sel_ex;
						ex_serve <= sel_ex;
						state <= memsys_pkg::st_idle;
					end
				end
				memsys_pkg::st_wb: begin
					ram_en <= 1'b1;
					ram_we <= 1'b1;
					ram_doe <= 1'b0;
					if_serve <= !sel_ex;
					ex_serve <= sel_ex;
					state <= memsys_pkg::st_idle;
				end
				default: state <= memsys_pkg::st_idle;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Address and data
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (take_ex || take_if) begin
			addr_q <= cache_addr;
			ram_addr <= cache_addr;
			wdata_q <= ex_wdata;
			if (hit)
				serve_data <= hit_data;
		end
		// Read word is both the result and the fill data
		if (state == memsys_pkg::st_rd2)
			serve_data <= ram_din;
		// Victim taken before the fill overwrites the line
		if (state == memsys_pkg::st_fill && victim_need) begin
			ram_addr <= victim_addr;
			ram_dout <= victim_data;
		end
	end

	a_strobe_excl: assert property (@(posedge clk) disable iff (!rst)
		ram_oe || ram_we);

	a_doe_with_we: assert property (@(posedge clk) disable iff (!rst)
		ram_doe == !ram_we);

endmodule

/* verilog/memsys_top.sv */
`timescale 1ns/1ps

module memsys_top #(
	parameter int lines = 64
) (
	input logic clk,
	input logic rst,
	// Instruction fetch
	input logic if_req,
	input logic [memsys_pkg::addr_w-1:0] if_addr,
	output logic if_done,
	output logic [memsys_pkg::data_w-1:0] if_data,
	// Load and store
	input logic ex_req,
	input logic ex_rd,
	input logic [memsys_pkg::addr_w-1:0] ex_addr,
	input logic [memsys_pkg::data_w-1:0] ex_wdata,
	input logic [memsys_pkg::act_w-1:0] ex_act,
	output logic ex_done,
	output logic [memsys_pkg::data_w-1:0] ex_data,
	output logic [memsys_pkg::act_w-1:0] ex_act_done,
	// Off-chip SRAM, data bus split
	output logic [memsys_pkg::addr_w-1:0] ram_addr,
	output logic ram_en,
	output logic ram_oe,
	output logic ram_we,
	output logic [memsys_pkg::data_w-1:0] ram_dout,
	output logic ram_doe,
	input logic [memsys_pkg::data_w-1:0] ram_din,
	output memsys_pkg::seq_state_t state
);

	logic if_pending;
	logic if_serve;
	logic ex_pending;
	logic ex_serve;
	logic [memsys_pkg::data_w-1:0] serve_data;
	logic [memsys_pkg::addr_w-1:0] cache_addr;
	logic cache_wr;
	logic [memsys_pkg::data_w-1:0] cache_wdata;
	logic cache_dirty_set;
	logic hit;
	logic [memsys_pkg::data_w-1:0] hit_data;
	logic victim_need;
	logic [memsys_pkg::addr_w-1:0] victim_addr;
	logic [memsys_pkg::data_w-1:0] victim_data;

	fetch_port u_fetch_port (
		.clk(clk),
		.rst(rst),
		.if_req(if_req),
		.if_addr(if_addr),
		.if_serve(if_serve),
		.serve_data(serve_data),
		.if_pending(if_pending),
		.if_done(if_done),
		.if_data(if_data)
	);

	data_port u_data_port (
		.clk(clk),
		.rst(rst),
		.ex_req(ex_req),
		.ex_rd(ex_rd),
		.ex_act(ex_act),
		.ex_serve(ex_serve),
		.serve_data(serve_data),
		.ex_pending(ex_pending),
		.ex_done(ex_done),
		.ex_data(ex_data),
		.ex_act_done(ex_act_done)
	);

	line_cache #(
		.lines(lines)
	) u_line_cache (
		.clk(clk),
		.rst(rst),
		.cache_addr(cache_addr),
		.cache_wr(cache_wr),
		.cache_wdata(cache_wdata),
		.cache_dirty_set(cache_dirty_set),
		.hit(hit),
		.hit_data(hit_data),
		.victim_need(victim_need),
		.victim_addr(victim_addr),
		.victim_data(victim_data)
	);

	sram_sequencer #(
		.lines(lines)
	) u_sram_sequencer (
		.clk(clk),
		.rst(rst),
		.if_pending(if_pending),
		.if_addr(if_addr),
		.ex_pending(ex_pending),
		.ex_rd(ex_rd),
		.ex_addr(ex_addr),
		.ex_wdata(ex_wdata),
		.hit(hit),
		.hit_data(hit_data),
		.victim_need(victim_need),
		.victim_addr(victim_addr),
		.victim_data(victim_data),
		.ram_din(ram_din),
		.cache_addr(cache_addr),
		.cache_wr(cache_wr),
		.cache_wdata(cache_wdata),
		.cache_dirty_set(cache_dirty_set),
		.if_serve(if_serve),
		.ex_serve(ex_serve),
		.serve_data(serve_data),
		.ram_addr(ram_addr),
		.ram_en(ram_en),
		.ram_oe(ram_oe),
		.ram_we(ram_we),
		.ram_dout(ram_dout),
		.ram_doe(ram_doe),
		.state(state)
	);

endmodule

/* verification/sram_model.sv */
`timescale 1ns/1ps

module sram_model (
	input logic [15:0] addr,
	input logic en,
	input logic oe,
	input logic we,
	input logic [15:0] wdata,
	output logic [15:0] rdata,
	output int rd_count,
	output int wr_count,
	output logic [15:0] last_wr_addr,
	output logic [15:0] last_wr_data
);

	logic [15:0] mem [65536];
	logic wr_armed;

	// Preset pattern, every word is its address xor 5a5a
	initial begin
		for (int i = 0; i < 65536; i++)
			mem[i] = i[15:0] ^ 16'h5a5a;
		rd_count = 0;
		wr_count = 0;
		last_wr_addr = '0;
		last_wr_data = '0;
		wr_armed = 1'b0;
	end

	// Asynchronous read while chip and output enables are low
	assign rdata = (!en && !oe) ? mem[addr] : 16'h0000;

	always @(negedge oe)
		rd_count++;

	// Write cycle opens when the write strobe falls with the chip enabled
	always @(negedge we)
		wr_armed = !en;

	// Write lands on the trailing edge of the write strobe
	always @(posedge we) begin
		if (wr_armed) begin
			mem[addr] = wdata;
			wr_count++;
			last_wr_addr = addr;
			last_wr_data = wdata;
			wr_armed = 1'b0;
		end
	end

endmodule

/* verification/memsys_tb.sv */
`timescale 1ns/1ps

module memsys_tb;

	localparam int lines = 64;
	localparam int n_mix = 200;
	localparam int n_req = n_mix + 40;
	localparam int clk_ns = 10;

	logic clk;
	logic rst;
	logic if_req;
	logic [15:0] if_addr;
	logic if_done;
	logic [15:0] if_data;
	logic ex_req;
	logic ex_rd;
	logic [15:0] ex_addr;
	logic [15:0] ex_wdata;
	logic [31:0] ex_act;
	logic ex_done;
	logic [15:0] ex_data;
	logic [31:0] ex_act_done;
	logic [15:0] ram_addr;
	logic ram_en;
	logic ram_oe;
	logic ram_we;
	logic [15:0] ram_dout;
	logic ram_doe;
	logic [15:0] ram_din;
	logic [15:0] sram_q;
	memsys_pkg::seq_state_t state;
	int rd_count;
	int wr_count;
	logic [15:0] last_wr_addr;
	logic [15:0] last_wr_data;

	logic [15:0] shadow [65536];
	logic [31:0] lfsr_state;
	logic [31:0] token;
	logic [15:0] exp_if;
	logic [15:0] exp_ex;
	logic [31:0] exp_tok;
	logic exp_ex_rd;
	logic if_done_q;
	logic ex_done_q;
	int err_data;
	int err_ctrl;

	memsys_top #(
		.lines(lines)
	) u_memsys_top (
		.clk(clk),
		.rst(rst),
		.if_req(if_req),
		.if_addr(if_addr),
		.if_done(if_done),
		.if_data(if_data),
		.ex_req(ex_req),
		.ex_rd(ex_rd),
		.ex_addr(ex_addr),
		.ex_wdata(ex_wdata),
		.ex_act(ex_act),
		.ex_done(ex_done),
		.ex_data(ex_data),
		.ex_act_done(ex_act_done),
		.ram_addr(ram_addr),
		.ram_en(ram_en),
		.ram_oe(ram_oe),
		.ram_we(ram_we),
		.ram_dout(ram_dout),
		.ram_doe(ram_doe),
		.ram_din(ram_din),
		.state(state)
	);

	// Bus resolution, the controller drives only while writing
	assign ram_din = ram_doe ? ram_dout : sram_q;

	sram_model u_sram_model (
		.addr(ram_addr),
		.en(ram_en),
		.oe(ram_oe),
		.we(ram_we),
		.wdata(ram_dout),
		.rdata(sram_q),
		.rd_count(rd_count),
		.wr_count(wr_count),
		.last_wr_addr(last_wr_addr),
		.last_wr_data(last_wr_data)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_ns / 2) clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// Reference and random source
	//////////////////////////////////////////////////////////////////////

	function automatic logic [15:0] ref_word(input logic [15:0] a);
		return shadow[a];
	endfunction

	// Fibonacci LFSR, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] next_bits(input int n);
		logic [31:0] r;
		logic fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Compare on each rising done level
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		#1;
		if (rst) begin
			if (if_done && !if_done_q)
				assert (if_data == exp_if) else begin
					$display("MISMATCH if_data at %h: got %h expected %h",
						if_addr, if_data, exp_if);
					err_data++;
				end
			if (ex_done && !ex_done_q) begin
				assert (ex_act_done == exp_tok) else begin
					$display("MISMATCH ex_act_done: got %h expected %h", ex_act_done, exp_tok);
					err_data++;
				end
				if (exp_ex_rd)
					assert (ex_data == exp_ex) else begin
						$display("MISMATCH ex_data at %h: got %h expected %h",
							ex_addr, ex_data, exp_ex);
						err_data++;
					end
			end
		end
		if_done_q = if_done;
		ex_done_q = ex_done;
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus tasks, called on the falling edge
	//////////////////////////////////////////////////////////////////////

	task automatic start_fetch(input logic [15:0] a);
		if_req = 1'b1;
		if_addr = a;
		exp_if = ref_word(a);
	endtask

	task automatic start_data(input logic rd, input logic [15:0] a, input logic [15:0] d);
		token = token + 1;
		ex_req = 1'b1;
		ex_rd = rd;
		ex_addr = a;
		ex_wdata = d;
		ex_act = token;
		exp_tok = token;
		exp_ex_rd = rd;
		if (rd)
			exp_ex = ref_word(a);
		else
			shadow[a] = d;
	endtask

	// Waits for both done levels, records the cycle each one rose
	task automatic wait_done(input logic want_if, input logic want_ex, output int if_t,
		output int ex_t);
		int n;
		n = 0;
		if_t = 0;
		ex_t = 0;
		while (n < 60 && ((want_if && if_t == 0) || (want_ex && ex_t == 0))) begin
			@(negedge clk);
			n++;
			if (if_done && if_t == 0)
				if_t = n;
			if (ex_done && ex_t == 0)
				ex_t = n;
		end
		if ((want_if && if_t == 0) || (want_ex && ex_t == 0)) begin
			$display("Timed out waiting for a done level");
			err_ctrl++;
		end
	endtask

	// Fetch address that is new to the fetch port
	function automatic logic [15:0] fresh_fetch_addr();
		logic [15:0] a;
		a = 16'(next_bits(10));
		if (a == if_addr)
			a = a ^ 16'h0001;
		return a;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		int t_if;
		int t_ex;
		int rc;
		int wc;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] d;
		logic [1:0] op;
		rst = 1'b0;
		if_req = 1'b0;
		if_addr = '0;
		ex_req = 1'b0;
		ex_rd = 1'b1;
		ex_addr = '0;
		ex_wdata = '0;
		ex_act = '0;
		token = '0;
		exp_if = '0;
		exp_ex = '0;
		exp_tok = '0;
		exp_ex_rd = 1'b0;
		if_done_q = 1'b0;
		ex_done_q = 1'b0;
		err_data = 0;
		err_ctrl = 0;
		lfsr_state = 32'hbdcf;
		for (int i = 0; i < 65536; i++)
			shadow[i] = i[15:0] ^ 16'h5a5a;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b1;

		// Idle outputs after reset
		assert (ram_oe && ram_we && ram_en && !if_done && !ex_done
			&& state == memsys_pkg::st_idle) else begin
			$display("Outputs not idle after reset");
			err_ctrl++;
		end

		// Fetches of the preset pattern
		repeat (8) begin
			start_fetch(fresh_fetch_addr());
			wait_done(1'b1, 1'b0, t_if, t_ex);
		end
		rc = rd_count;
		start_fetch(if_addr);
		repeat (3) @(negedge clk);
		assert (rd_count == rc && if_done) else begin
			$display("Repeated fetch strobed the SRAM or dropped if_done");
			err_ctrl++;
		end

		// Store then load with a new token
		a = 16'(next_bits(10));
		d = 16'(next_bits(16));
		start_data(1'b0, a, d);
		wait_done(1'b0, 1'b1, t_if, t_ex);
		start_data(1'b1, a, 16'h0000);
		wait_done(1'b0, 1'b1, t_if, t_ex);

		// Conflicting stores force a write-back of the first word
		a = 16'(next_bits(10));
		d = 16'(next_bits(16));
		start_data(1'b0, a, d);
		wait_done(1'b0, 1'b1, t_if, t_ex);
		wc = wr_count;
		start_data(1'b0, a ^ 16'h0100, 16'(next_bits(16)));
		wait_done(1'b0, 1'b1, t_if, t_ex);
		assert (wr_count == wc + 1 && last_wr_addr == a && last_wr_data == d) else begin
			$display("MISMATCH write-back: writes %h addr %h data %h, expected %h %h %h",
				wr_count - wc, last_wr_addr, last_wr_data, 1, a, d);
			err_data++;
		end
		start_data(1'b0, a ^ 16'h0200, 16'(next_bits(16)));
		wait_done(1'b0, 1'b1, t_if, t_ex);
		start_data(1'b1, a, 16'h0000);
		wait_done(1'b0, 1'b1, t_if, t_ex);

		// Both ports in the same cycle, data port served first
		repeat (4) begin
			b = 16'(next_bits(10));
			start_fetch(fresh_fetch_addr());
			start_data(1'b1, b, 16'h0000);
			wait_done(1'b1, 1'b1, t_if, t_ex);
			assert (t_ex <= t_if) else begin
				$display("ex_done rose after if_done (cycle %0d vs %0d)", t_ex, t_if);
				err_ctrl++;
			end
		end

		// Random mix
		repeat (n_mix) begin
			op = 2'(next_bits(2));
			a = 16'(next_bits(10));
			d = 16'(next_bits(16));
			if (op == 2'd0) begin
				start_fetch(fresh_fetch_addr());
				wait_done(1'b1, 1'b0, t_if, t_ex);
			end else begin
				start_data(op == 2'd1, a, d);
				wait_done(1'b0, 1'b1, t_if, t_ex);
			end
		end

		if_req = 1'b0;
		ex_req = 1'b0;
		repeat (2) @(negedge clk);
		$display("Errors: data %0d, control %0d", err_data, err_ctrl);
		if (err_data + err_ctrl == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	// Watchdog, 20 cycles per request plus a margin
	initial begin
		#(n_req * 20 * clk_ns + 1000);
		$display("Watchdog expired before the sequence finished");
		$display("** FAIL **");
		$finish;
	end

endmodule

/* memsys.f */
verilog/memsys_pkg.sv
verilog/fetch_port.sv
verilog/data_port.sv
verilog/line_cache.sv
verilog/sram_sequencer.sv
verilog/memsys_top.sv
verification/sram_model.sv
verification/memsys_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the memsys testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f memsys.f --top-module memsys_tb -o memsys_sim \
	&& ./obj_dir/memsys_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q '^\*\* PASS \*\*$' sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
